/* bcd_print.f */
logic/bcd_types_pkg.sv
logic/link_pkg.sv
logic/number_intake.sv
logic/double_dabble.sv
logic/digit_emitter.sv
logic/bcd_print_top.sv
testbench/tb_bcd_print.sv

/* run_sim.sh */
#!/bin/sh
# builds the print engine testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f bcd_print.f \
	--top-module tb_bcd_print -o sim_bcd_print > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_bcd_print > sim.log 2>&1
cat sim.log

grep -qx "Everything OK" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* testbench/tb_bcd_print.sv */
// testbench for the decimal print engine
// directed tests over both credit links, decimal reference model,
// credit models for sender and receiver, watchdog and error counts

`timescale 1ns/1ps

module tb_bcd_print import bcd_types_pkg::*, link_pkg::*;;

	localparam int FIFO_DEPTH      = 4;
	localparam int OUT_CREDITS     = 6;
	localparam int NUM_TOTAL       = 60;                     // numbers over all tests
	localparam int WATCHDOG_CYCLES = NUM_TOTAL * 200 + 2000; // 200 per number plus margin

	logic  clk, reset, in_valid, out_credit;
	logic  in_credit, out_valid;
	num_t  in_data;
	char_t out_char;

	int    seed = 32'h93e9_95d3;
	int    cycle = 0;               // rising edges since start
	int    in_credits = FIFO_DEPTH; // sender model
	int    dut_credits = OUT_CREDITS; // output credits the DUT should hold
	int    credit_pulses = 0;       // in_credit pulses seen
	int    chars_seen = 0;
	int    due[$];                  // cycles at which out_credit is owed
	int    delay;
	bit    hold_credits = 0;        // receiver withholds out_credit
	bit    rand_delay = 0;          // random credit return delay
	string expected[$];             // reference lines in send order
	string line_buf = "";           // characters of the current line
	string exp_line;
	string cur_test = "reset";
	int    mismatch_errors = 0;
	int    protocol_errors = 0;

	bcd_print_top #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) DUT (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.out_credit (out_credit),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_char   (out_char)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	always @(posedge clk) cycle++;

	// decimal text of n by repeated division by ten plus a line feed
	function automatic string dec_string(input num_t n);
		string s;
		num_t  v;
		s = "";
		v = n;
		do begin
			s = $sformatf("%0d%s", v % 10, s); // lowest digit goes in front
			v = v / 10;
		end while (v != 0);
		return {s, "\n"};
	endfunction

	// line feed shown as \n in messages
	function automatic string show_line(input string s);
		string r;
		r = "";
		for (int i = 0; i < s.len(); i++) begin
			if (s[i] == 8'h0A)
				r = {r, "\\n"};
			else
				r = {r, s.substr(i, i)};
		end
		return r;
	endfunction

	// receiver returns owed credits one per cycle
	initial begin
		out_credit = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			out_credit = 1'b0;
			if (!hold_credits) begin
				for (int i = 0; i < due.size(); i++) begin
					if (due[i] <= cycle) begin
						due.delete(i);
						out_credit = 1'b1;
						break; // one credit per cycle and the rest slip
					end
				end
			end
		end
	end

	// monitors sample at the falling edge where outputs are settled
	always @(negedge clk) begin
		if (!reset) begin
			if (in_credit) begin
				in_credits++;
				credit_pulses++;
				assert (in_credits <= FIFO_DEPTH) else begin
					protocol_errors++;
					$display("%s: in_credit returned more credits than FIFO slots", cur_test);
				end
			end
			if (out_valid) begin
				assert (dut_credits > 0) else begin
					protocol_errors++;
					$display("%s: out_valid asserted with no output credit left", cur_test);
				end
				chars_seen++;
				dut_credits--;
				delay = rand_delay ? 1 + ($random(seed) & 3) : 2;
				due.push_back(cycle + delay);
				line_buf = $sformatf("%s%c", line_buf, out_char);
				if (out_char == CHAR_LF) begin // end of a number
					if (expected.size() == 0) begin
						protocol_errors++;
						$display("%s: a line came out with no number outstanding", cur_test);
					end else begin
						exp_line = expected.pop_front();
						assert (line_buf == exp_line) else begin
							mismatch_errors++;
							$display("MISMATCH %s: expected %s, actual %s", cur_test,
								show_line(exp_line), show_line(line_buf));
						end
					end
					line_buf = "";
				end
			end
			if (out_credit)
				dut_credits++;
		end
	end

	// sends one number over the input link once a credit is held
	task automatic send_number(input num_t n);
		int waited;
		waited = 0;
		while (in_credits == 0 && waited < 1000) begin
			@(posedge clk);
			#1;
			waited++;
		end
		assert (in_credits > 0) else begin
			protocol_errors++;
			$display("%s: no input credit came back for %0d cycles", cur_test, waited);
		end
		in_valid = 1'b1;
		in_data  = n;
		in_credits--;
		expected.push_back(dec_string(n));
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	// waits until every sent number has printed
	task automatic wait_drained();
		int limit;
		int waited;
		limit  = expected.size() * 200 + 200;
		waited = 0;
		while ((expected.size() != 0 || line_buf.len() != 0) && waited < limit) begin
			@(posedge clk);
			#1;
			waited++;
		end
		assert (expected.size() == 0 && line_buf.len() == 0) else begin
			protocol_errors++;
			$display("%s: %0d lines still missing after %0d cycles", cur_test,
				expected.size(), limit);
		end
	endtask

	task automatic test_single();
		cur_test = "single";
		send_number(32'd0); // prints as one zero
		send_number(32'd7);
		send_number(32'd10);
		send_number(32'd99999999);
		send_number(32'd4294967295);
		wait_drained();
	endtask

	task automatic test_zeros();
		cur_test = "zeros";
		send_number(32'd1000000); // inner zeros stay
		send_number(32'd100);
		wait_drained();
	endtask

	// back to back and then more as credits return
	task automatic test_burst();
		int pulses0;
		pulses0  = credit_pulses;
		cur_test = "burst";
		for (int i = 0; i < 10; i++)
			send_number(num_t'(1000 + i * 37));
		wait_drained();
		assert (credit_pulses - pulses0 == 10) else begin
			mismatch_errors++;
			$display("MISMATCH %s: expected %0d, actual %0d", cur_test, 10,
				credit_pulses - pulses0);
		end
		assert (in_credits == FIFO_DEPTH) else begin
			mismatch_errors++;
			$display("MISMATCH %s: expected %0d, actual %0d", cur_test, FIFO_DEPTH,
				in_credits);
		end
	endtask

	// out_credit held back while the first line is longer than the credits
	// second result parks in the result register
	// third conversion stalls in the done-wait state
	task automatic test_backpressure();
		int chars0;
		int waited;
		int hold_cycles;
		cur_test    = "backpressure";
		waited      = 0;
		hold_cycles = 3 * 2 * NUM_WIDTH + 40; // three conversions and their idle cycles
		while (due.size() != 0 && waited < 100) begin // all credits home
			@(posedge clk);
			#1;
			waited++;
		end
		hold_credits = 1'b1;
		chars0       = chars_seen;
		send_number(32'd4294967295); // eleven characters
		send_number(32'd305419896);
		send_number(32'd20);
		repeat (hold_cycles) @(posedge clk);
		#1;
		assert (chars_seen - chars0 == OUT_CREDITS) else begin
			mismatch_errors++;
			$display("MISMATCH %s: expected %0d characters, actual %0d", cur_test,
				OUT_CREDITS, chars_seen - chars0);
		end
		hold_credits = 1'b0;
		wait_drained();
	endtask

	task automatic test_random();
		num_t n;
		cur_test   = "random";
		rand_delay = 1'b1;
		for (int i = 0; i < 40; i++) begin
			n = num_t'($random(seed)) >> ($random(seed) & 31); // vary the length
			send_number(n);
		end
		wait_drained();
		rand_delay = 1'b0;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

	initial begin
		reset    = 1'b1;
		in_valid = 1'b0;
		in_data  = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		test_single();
		test_zeros();
		test_burst();
		test_backpressure();
		test_random();
		$display("errors: %0d mismatches, %0d protocol", mismatch_errors, protocol_errors);
		if (mismatch_errors == 0 && protocol_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* logic/bcd_print_top.sv */
// decimal print engine, top level
// numbers in over a credit link, converted to bcd, printed out as
// ascii lines over a second credit link

`timescale 1ns/1ps

module bcd_print_top import bcd_types_pkg::*, link_pkg::*; #(
	parameter int FIFO_DEPTH  = 4, // intake slots, initial input credits
	parameter int OUT_CREDITS = 6  // initial output credits
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  in_valid,
	input  num_t  in_data,
	input  logic  out_credit,
	output logic  in_credit,
	output logic  out_valid,
	output char_t out_char
);

	// intake to converter
	logic      pend_valid;
	num_t      pend_data;
	logic      pend_take;

	// converter to emitter
	logic      res_valid;
	bcd_word_t res_bcd;
	logic      res_take;

	number_intake #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_intake (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.pend_take  (pend_take),
		.in_credit  (in_credit),
		.pend_valid (pend_valid),
		.pend_data  (pend_data)
	);

	double_dabble u_convert (
		.clk        (clk),
		.reset      (reset),
		.pend_valid (pend_valid),
		.pend_data  (pend_data),
		.res_take   (res_take),
		.pend_take  (pend_take),
		.res_valid  (res_valid),
		.res_bcd    (res_bcd)
	);

	digit_emitter #(
		.OUT_CREDITS(OUT_CREDITS)
	) u_emit (
		.clk        (clk),
		.reset      (reset),
		.res_valid  (res_valid),
		.res_bcd    (res_bcd),
		.out_credit (out_credit),
		.res_take   (res_take),
		.out_valid  (out_valid),
		.out_char   (out_char)
	);

endmodule

/* logic/digit_emitter.sv */
// output side of the print engine
// loads a bcd result, skips leading zeros and sends the digits as
// ascii characters, most significant first, then a line feed
// one output credit is spent per character

`timescale 1ns/1ps

module digit_emitter import bcd_types_pkg::*, link_pkg::*; #(
	parameter int OUT_CREDITS = 6
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      res_valid,  // converter result ready
	input  bcd_word_t res_bcd,
	input  logic      out_credit, // receiver consumed one character
	output logic      res_take,   // result loaded
	output logic      out_valid,  // out_char is sent this cycle
	output char_t     out_char
);

	localparam int IDX_W = $clog2(BCD_DIGITS);

	bcd_word_t               word;    // number being printed
	logic [IDX_W-1:0]        idx;     // digit to send next
	logic [IDX_W-1:0]        top_idx; // highest non-zero digit of res_bcd
	logic                    busy;    // a line is in progress
	logic                    send_lf; // all digits out, line feed next
	logic [CREDIT_CNT_W-1:0] credits; // characters the receiver can take

	// highest non-zero digit, digit 0 for an all-zero word
	always_comb begin
		top_idx = '0;
		for (int i = 0; i < BCD_DIGITS; i++) begin
			if (res_bcd.digit[i] != 4'd0)
				top_idx = IDX_W'(i); // later hits are more significant
		end
	end

	assign res_take  = !busy && res_valid;
	assign out_valid = busy && (credits != '0); // stall with no credit
	assign out_char  = send_lf ? CHAR_LF : (CHAR_ZERO + char_t'(word.digit[idx]));

	always_ff @(posedge clk) begin
		if (res_take)
			word <= res_bcd;
	end

	// line sequencing
	always_ff @(posedge clk) begin
		if (reset) begin
			busy    <= 1'b0;
			send_lf <= 1'b0;
			idx     <= '0;
		end else if (res_take) begin
			busy    <= 1'b1;
			send_lf <= 1'b0;
			idx     <= top_idx;
		end else if (out_valid) begin
			if (send_lf)
				busy <= 1'b0;    // line done
			else if (idx == '0)
				send_lf <= 1'b1; // units digit just went out
			else
				idx <= idx - 1'b1;
		end
	end

	// credit counter, return and spend may coincide
	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= CREDIT_CNT_W'(OUT_CREDITS);
		end else begin
			case ({out_credit, out_valid})
			2'b10:   credits <= credits + 1'b1;
			2'b01:   credits <= credits - 1'b1;
			default: credits <= credits;
			endcase
		end
	end

endmodule

/* logic/double_dabble.sv */
// binary to bcd converter, shift and add-3 sequencer
// takes one number from the intake, runs 32 shifts and 31 add-3 steps,
// then parks the result in a holding register for the emitter
// a second number may convert while the first waits there

`timescale 1ns/1ps

module double_dabble import bcd_types_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      pend_valid, // intake holds a number
	input  num_t      pend_data,
	input  logic      res_take,   // emitter loads res_bcd
	output logic      pend_take,  // number loaded, slot freed
	output logic      res_valid,  // result register full
	output bcd_word_t res_bcd
);

	// one-hot state codes
	localparam logic [3:0] S_IDLE  = 4'b0001;
	localparam logic [3:0] S_SHIFT = 4'b0010;
	localparam logic [3:0] S_ADD3  = 4'b0100;
	localparam logic [3:0] S_WAIT  = 4'b1000; // done, result register busy

	localparam int ITER_W = $clog2(NUM_WIDTH);

	logic [3:0]        state;
	logic [ITER_W-1:0] iter;          // shift steps done so far
	num_t              bin;           // input bits still to shift, msb first
	bcd_word_t         work;          // working bcd word
	bcd_word_t         work_shifted;
	bcd_word_t         work_fixed;
	logic              last_step;     // final shift of this number
	logic              res_free;      // result register can be loaded

	assign pend_take = (state == S_IDLE) && pend_valid;
	assign last_step = (iter == ITER_W'(NUM_WIDTH - 1));
	assign res_free  = !res_valid || res_take; // freed by the take itself

	// next input bit into the bottom of the bcd word
	assign work_shifted.flat = {work.flat[BCD_WIDTH-2:0], bin[NUM_WIDTH-1]};

	// add 3 to every digit of five or more
	always_comb begin
		work_fixed = work;
		for (int i = 0; i < BCD_DIGITS; i++) begin
			if (work.digit[i] >= 4'd5)
				work_fixed.digit[i] = work.digit[i] + 4'd3;
		end
	end

	// control
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= S_IDLE;
			iter      <= '0;
			res_valid <= 1'b0;
		end else begin
			if (res_take)
				res_valid <= 1'b0; // a load below takes priority
			case (state)
			S_IDLE: begin
				iter <= '0;
				if (pend_take)
					state <= S_SHIFT;
			end
			S_SHIFT: begin
				iter <= iter + 1'b1;
				if (!last_step) begin
					state <= S_ADD3;
				end else if (res_free) begin
					res_valid <= 1'b1;
					state     <= S_IDLE;
				end else begin
					state <= S_WAIT; // hold until emitter takes the old one
				end
			end
			S_ADD3:  state <= S_SHIFT;
			S_WAIT: begin
				if (res_free) begin
					res_valid <= 1'b1;
					state     <= S_IDLE;
				end
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		case (state)
		S_IDLE: begin
			if (pend_take) begin
				bin  <= pend_data;
				work <= '0;
			end
		end
		S_SHIFT: begin
			work <= work_shifted;
			bin  <= bin << 1;
			if (last_step && res_free)
				res_bcd <= work_shifted; // straight into the result register
		end
		S_ADD3:  work <= work_fixed;
		S_WAIT: begin
			if (res_free)
				res_bcd <= work;
		end
		default: ;
		endcase
	end

endmodule

/* logic/number_intake.sv */
// input side of the print engine
// stores incoming numbers in a small circular FIFO and hands them
// to the converter in arrival order, one credit back per freed slot

`timescale 1ns/1ps

module number_intake import bcd_types_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,   // one number, sender holds a credit
	input  num_t in_data,
	input  logic pend_take,  // converter loads pend_data
	output logic in_credit,  // one slot freed
	output logic pend_valid, // fifo not empty
	output num_t pend_data
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	num_t             slots [FIFO_DEPTH]; // number storage
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;              // occupied slots
	logic             do_write, do_read;

	// pointer step with wrap, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign pend_valid = (count != '0);
	assign pend_data  = slots[rd_ptr]; // head of queue

	// a full fifo never takes a write, sender is out of credits then
	assign do_write = in_valid && (count != CNT_W'(FIFO_DEPTH));
	assign do_read  = pend_take && pend_valid;

	always_ff @(posedge clk) begin
		if (do_write)
			slots[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			in_credit <= do_read; // credit one cycle after the take
			if (do_write)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_read)
				rd_ptr <= ptr_inc(rd_ptr);

			case ({do_write, do_read})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count; // none, or one in and one out
			endcase
		end
	end

endmodule

/* logic/link_pkg.sv */
// character codes and constants for the two credit links
// output characters are plain ascii, one number per line

package link_pkg;

	// ascii character on the output link
	typedef logic [7:0] char_t;

	localparam char_t CHAR_ZERO = 8'h30; // "0", digits are added on top
	localparam char_t CHAR_LF   = 8'h0A; // line feed, ends each number

	// credit counter width, up to 15 credits outstanding
	localparam int CREDIT_CNT_W = 4;

endpackage

/* logic/bcd_types_pkg.sv */
// number and bcd formats for the print engine
// binary input word, decimal digit and the bcd result union

package bcd_types_pkg;

	localparam int NUM_WIDTH  = 32;             // binary input width
	localparam int BCD_DIGITS = 10;             // enough for 4294967295
	localparam int BCD_WIDTH  = 4 * BCD_DIGITS; // flat bcd word width

	// unsigned binary number
	typedef logic [NUM_WIDTH-1:0] num_t;

	// one decimal digit, 0..9
	typedef logic [3:0] bcd_digit_t;

	// bcd result word
	// flat view for shift and add-3, digit view for printing
	// digit 0 is the least significant
	typedef union packed {
		logic [BCD_WIDTH-1:0]        flat;
		bcd_digit_t [BCD_DIGITS-1:0] digit;
	} bcd_word_t;

endpackage
